/* Bender.yml */
package:
  name: sv32_mmu

export_include_dirs:
  - .

sources:
  - mmu_pkg.sv
  - mmu_tlb.sv
  - mmu_ptw.sv
  - mmu_xlate.sv
  - sv32_mmu.sv
  - target: test
    files:
      - sv32_mmu_assert.sv
      - tb_sv32_mmu.sv

/* flist.f */
+incdir+.
mmu_pkg.sv
mmu_tlb.sv
mmu_ptw.sv
mmu_xlate.sv
sv32_mmu.sv
sv32_mmu_assert.sv
tb_sv32_mmu.sv

/* mmu_pkg.sv */
// Sv32 MMU types
// page table entry, satp, virtual address views, TLB entry and exception

`include "mmu_settings.svh"

package mmu_pkg;

  // ------------------------------------------------------------
  // architectural words
  // ------------------------------------------------------------
  // Sv32 page table entry, lsb first is v
  typedef struct packed {
    logic [`MMU_PPNW-1:0] ppn;
    logic [1:0] rsw;
    logic d;
    logic a;
    logic g;
    logic u;
    logic x;
    logic w;
    logic r;
    logic v;
  } pte_t;

  // satp csr, mode 0 is bare, mode 1 is Sv32
  typedef struct packed {
    logic mode;
    logic [`MMU_ASIDW-1:0] asid;
    logic [`MMU_PPNW-1:0] ppn;
  } satp_t;

  // one virtual address, seen as a 4 KiB page or a 4 MiB megapage
  typedef union packed {
    struct packed {
      logic [9:0] vpn1;
      logic [9:0] vpn0;
      logic [11:0] offset;
    } page;
    struct packed {
      logic [9:0] vpn1;
      logic [21:0] offset;
    } mega;
  } vaddr_u;

  // ------------------------------------------------------------
  // MMU internal bundles
  // ------------------------------------------------------------
  // TLB slot, also the refill word out of the walker
  typedef struct packed {
    logic valid;
    logic is_mega;
    // vpn1 then vpn0, vpn0 ignored for megapages
    logic [19:0] vpn;
    logic [`MMU_ASIDW-1:0] asid;
    pte_t pte;
  } tlb_entry_t;

  // load/store exception
  typedef struct packed {
    logic valid;
    logic [3:0] cause;
    logic [`MMU_VLEN-1:0] tval;
  } xlate_exc_t;

  // effective privilege of the access
  typedef enum logic {
    PRIV_LVL_U = 1'b0,
    PRIV_LVL_S = 1'b1
  } priv_lvl_t;

endpackage

/* mmu_ptw.sv */
// Sv32 page table walker
// two-level walk with a read-only Wishbone classic master, refills the TLB

`timescale 1ns/1ps

`include "mmu_settings.svh"

module mmu_ptw (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  // miss from the TLB
  input  logic                    miss_i,
  input  mmu_pkg::vaddr_u         miss_vaddr_i,
  input  logic [`MMU_ASIDW-1:0]   miss_asid_i,
  input  logic [`MMU_PPNW-1:0]    root_ppn_i,
  // Wishbone classic master, reads only
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic [`MMU_PLEN-1:0]    wb_adr_o,
  input  logic [31:0]             wb_dat_i,
  input  logic                    wb_ack_i,
  input  logic                    wb_err_i,
  // TLB refill
  output logic                    refill_valid_o,
  output mmu_pkg::tlb_entry_t     refill_o,
  // walk result for the translation stage
  output logic                    walk_done_o,
  output logic                    walk_fault_o,
  output logic                    walk_cause_access_o,
  output mmu_pkg::vaddr_u         walk_vaddr_o
);
  import mmu_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_L1,
    S_L0,
    S_DONE
  } state_e;

  state_e state_q;
  logic cyc_q;
  logic done_q;
  logic fault_q;
  logic access_q;
  logic flushed_q;
  // walk payload
  logic [`MMU_PLEN-1:0] adr_q;
  vaddr_u vaddr_q;
  logic [`MMU_ASIDW-1:0] asid_q;
  pte_t pte_q;
  logic mega_q;
  // read data decode
  pte_t rd_pte;
  logic rd_bad;
  logic rd_leaf;
  logic rd_misaligned;
  logic resp;
  logic consume;
  logic start;

  assign rd_pte = pte_t'(wb_dat_i);
  // invalid, or the reserved w without r encoding
  assign rd_bad = !rd_pte.v || (rd_pte.w && !rd_pte.r);
  assign rd_leaf = rd_pte.r || rd_pte.x;
  // megapage must be 4 MiB aligned
  assign rd_misaligned = |rd_pte.ppn[9:0];
  assign resp = cyc_q && (wb_ack_i || wb_err_i);

  // retry of a faulted walk takes the fault instead of walking again
  assign consume = done_q && fault_q && (miss_vaddr_i == vaddr_q);
  assign start = (state_q == S_IDLE) && miss_i && !consume;

  // ------------------------------------------------------------
  // walk FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= S_IDLE;
      cyc_q     <= 1'b0;
      done_q    <= 1'b0;
      fault_q   <= 1'b0;
      access_q  <= 1'b0;
      flushed_q <= 1'b0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (miss_i) begin
            done_q <= 1'b0;
          end
          if (start) begin
            state_q   <= S_L1;
            cyc_q     <= 1'b1;
            fault_q   <= 1'b0;
            access_q  <= 1'b0;
            flushed_q <= 1'b0;
          end
        end
        S_L1, S_L0: begin
          if (!cyc_q) begin
            // level 0 read goes out one cycle after the level 1 answer
            cyc_q <= 1'b1;
          end else if (resp) begin
            cyc_q <= 1'b0;
            if (wb_err_i) begin
              fault_q  <= 1'b1;
              access_q <= 1'b1;
              state_q  <= S_DONE;
            end else if (rd_bad || (state_q == S_L0 && !rd_leaf) ||
                         (state_q == S_L1 && rd_leaf && rd_misaligned)) begin
              fault_q <= 1'b1;
              state_q <= S_DONE;
            end else if (rd_leaf) begin
              state_q <= S_DONE;
            end else begin
              // pointer at level 1
              state_q <= S_L0;
            end
          end
        end
        default: begin
          state_q <= S_IDLE;
          done_q  <= 1'b1;
        end
      endcase
      // refill of a walk that saw a flush is stale
      if (flush_i && state_q != S_IDLE) begin
        flushed_q <= 1'b1;
      end
    end
  end

  // walk payload, address moves only when stb is low or answered
  always_ff @(posedge clk_i) begin
    if (start) begin
      vaddr_q <= miss_vaddr_i;
      asid_q  <= miss_asid_i;
      adr_q   <= {root_ppn_i, miss_vaddr_i.page.vpn1, 2'b00};
    end else if (resp && wb_ack_i) begin
      pte_q  <= rd_pte;
      mega_q <= (state_q == S_L1);
      adr_q  <= {rd_pte.ppn, vaddr_q.page.vpn0, 2'b00};
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign wb_cyc_o = cyc_q;
  assign wb_stb_o = cyc_q;
  assign wb_adr_o = adr_q;

  assign refill_valid_o = (state_q == S_DONE) && !fault_q && !flushed_q && !flush_i;
  assign refill_o.valid = refill_valid_o;
  assign refill_o.is_mega = mega_q;
  assign refill_o.vpn = {vaddr_q.page.vpn1, vaddr_q.page.vpn0};
  assign refill_o.asid = asid_q;
  assign refill_o.pte = pte_q;

  assign walk_done_o = done_q;
  assign walk_fault_o = fault_q;
  assign walk_cause_access_o = access_q;
  assign walk_vaddr_o = vaddr_q;

endmodule

/* mmu_settings.svh */
// Sv32 data MMU constants
// address widths, TLB depth and trap cause codes

`ifndef MMU_SETTINGS_SVH
`define MMU_SETTINGS_SVH

// ------------------------------------------------------------
// address widths
// ------------------------------------------------------------
// virtual address, one 32-bit word
`define MMU_VLEN 32
// physical address, 22-bit ppn plus 12-bit page offset
`define MMU_PLEN 34
`define MMU_PPNW 22
// address space id out of satp
`define MMU_ASIDW 9

// ------------------------------------------------------------
// TLB
// ------------------------------------------------------------
// fully associative, small
`define MMU_TLB_ENTRIES 4

// ------------------------------------------------------------
// mcause codes for load/store faults
// ------------------------------------------------------------
`define MMU_CAUSE_LD_ACCESS 4'd5
`define MMU_CAUSE_ST_ACCESS 4'd7
`define MMU_CAUSE_LD_PAGE 4'd13
`define MMU_CAUSE_ST_PAGE 4'd15

`endif

/* mmu_tlb.sv */
// Fully associative data TLB for Sv32
// ASID and global match, 4 KiB and 4 MiB entries, round-robin refill, flush-all

`timescale 1ns/1ps

`include "mmu_settings.svh"

module mmu_tlb #(
  parameter int unsigned ENTRIES = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  // lookup, only when translation is on
  input  logic                    lu_req_i,
  input  mmu_pkg::vaddr_u         lu_vaddr_i,
  input  logic [`MMU_ASIDW-1:0]   lu_asid_i,
  // refill from the walker
  input  logic                    refill_valid_i,
  input  mmu_pkg::tlb_entry_t     refill_i,
  output logic                    lu_hit_o,
  output mmu_pkg::tlb_entry_t     lu_entry_o
);
  import mmu_pkg::*;

  localparam int unsigned IDXW = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  // slot payload, valid bits kept apart so only they need reset
  tlb_entry_t entry_q [ENTRIES];
  logic [ENTRIES-1:0] valid_q;
  logic [ENTRIES-1:0] match;
  // next victim
  logic [IDXW-1:0] rr_q;
  logic refill_we;

  assign refill_we = refill_valid_i && refill_i.valid;

  // ------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------
  for (genvar i = 0; i < ENTRIES; i++) begin : gen_match
    logic asid_ok;
    logic vpn_ok;

    // global pages ignore the asid
    assign asid_ok = entry_q[i].pte.g || (entry_q[i].asid == lu_asid_i);
    // megapage compares vpn1 only
    assign vpn_ok = entry_q[i].is_mega ?
                    (entry_q[i].vpn[19:10] == lu_vaddr_i.mega.vpn1) :
                    (entry_q[i].vpn == {lu_vaddr_i.page.vpn1, lu_vaddr_i.page.vpn0});
    assign match[i] = valid_q[i] && asid_ok && vpn_ok;
  end

  assign lu_hit_o = lu_req_i && (|match);

  // at most one slot matches, lowest index taken anyway
  always_comb begin
    lu_entry_o = '0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        lu_entry_o = entry_q[i];
      end
    end
    lu_entry_o.valid = lu_hit_o;
  end

  // ------------------------------------------------------------
  // refill and flush
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else begin
      if (refill_we) begin
        valid_q[rr_q] <= 1'b1;
        // wrap for depths that are not a power of two
        rr_q <= (rr_q == IDXW'(ENTRIES - 1)) ? '0 : rr_q + 1'b1;
      end
      // flush wins over a refill in the same cycle
      if (flush_i) begin
        valid_q <= '0;
      end
    end
  end

  // slot payload
  always_ff @(posedge clk_i) begin
    if (refill_we) begin
      entry_q[rr_q] <= refill_i;
    end
  end

endmodule

/* mmu_xlate.sv */
// Sv32 translation stage
// one register stage, physical address build, permission checks, trap select

`timescale 1ns/1ps

`include "mmu_settings.svh"

module mmu_xlate (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // request and TLB answer in the lookup cycle
  input  logic                    req_i,
  input  mmu_pkg::vaddr_u         vaddr_i,
  input  logic                    is_store_i,
  input  logic                    xlate_en_i,
  input  logic                    hit_i,
  input  mmu_pkg::tlb_entry_t     entry_i,
  // csr state
  input  mmu_pkg::priv_lvl_t      priv_i,
  input  logic                    sum_i,
  input  logic                    mxr_i,
  // walk result
  input  logic                    walk_done_i,
  input  logic                    walk_fault_i,
  input  logic                    walk_cause_access_i,
  output logic                    dtlb_hit_o,
  output logic                    valid_o,
  output logic [`MMU_PLEN-1:0]    paddr_o,
  output mmu_pkg::xlate_exc_t     exc_o
);
  import mmu_pkg::*;

  logic req_q;
  logic en_q;
  logic hit_q;
  logic wfault_q;
  logic store_q;
  logic waccess_q;
  vaddr_u vaddr_q;
  tlb_entry_t entry_q;
  pte_t pte;
  logic perm_err;

  // bare mode is always ready
  assign dtlb_hit_o = xlate_en_i ? hit_i : 1'b1;

  // ------------------------------------------------------------
  // stage register
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q    <= 1'b0;
      en_q     <= 1'b0;
      hit_q    <= 1'b0;
      wfault_q <= 1'b0;
    end else begin
      req_q <= req_i;
      en_q  <= xlate_en_i;
      hit_q <= hit_i;
      // missed retry of a walk that faulted
      wfault_q <= req_i && xlate_en_i && !hit_i && walk_done_i && walk_fault_i;
    end
  end

  always_ff @(posedge clk_i) begin
    vaddr_q   <= vaddr_i;
    store_q   <= is_store_i;
    entry_q   <= entry_i;
    waccess_q <= walk_cause_access_i;
  end

  // ------------------------------------------------------------
  // address and checks
  // ------------------------------------------------------------
  assign pte = entry_q.pte;
  assign valid_o = req_q && (!en_q || hit_q || wfault_q);

  always_comb begin
    if (!en_q) begin
      paddr_o = {{(`MMU_PLEN - `MMU_VLEN){1'b0}}, vaddr_q};
    end else if (entry_q.is_mega) begin
      // ppn1 on top of the 22-bit offset
      paddr_o = {pte.ppn[`MMU_PPNW-1:10], vaddr_q.mega.offset};
    end else begin
      paddr_o = {pte.ppn, vaddr_q.page.offset};
    end
  end

  // every failing check is a page fault
  always_comb begin
    perm_err = 1'b0;
    if (store_q && !(pte.w && pte.d)) begin
      perm_err = 1'b1;
    end else if (!store_q && !(pte.r || (pte.x && mxr_i))) begin
      // mxr lets loads read execute-only pages
      perm_err = 1'b1;
    end else if (!pte.a) begin
      perm_err = 1'b1;
    end else if (priv_i == PRIV_LVL_U && !pte.u) begin
      perm_err = 1'b1;
    end else if (priv_i == PRIV_LVL_S && pte.u && !sum_i) begin
      perm_err = 1'b1;
    end
  end

  always_comb begin
    exc_o = '0;
    if (req_q && en_q) begin
      if (wfault_q) begin
        exc_o.valid = 1'b1;
        exc_o.tval  = vaddr_q;
        if (waccess_q) begin
          exc_o.cause = store_q ? `MMU_CAUSE_ST_ACCESS : `MMU_CAUSE_LD_ACCESS;
        end else begin
          exc_o.cause = store_q ? `MMU_CAUSE_ST_PAGE : `MMU_CAUSE_LD_PAGE;
        end
      end else if (hit_q && perm_err) begin
        exc_o.valid = 1'b1;
        exc_o.tval  = vaddr_q;
        exc_o.cause = store_q ? `MMU_CAUSE_ST_PAGE : `MMU_CAUSE_LD_PAGE;
      end
    end
  end

endmodule

/* sv32_mmu.sv */
// Sv32 data MMU top
// DTLB, page table walker on Wishbone and the registered translation stage

`timescale 1ns/1ps

`include "mmu_settings.svh"

module sv32_mmu (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  // csr state
  input  mmu_pkg::satp_t          satp_i,
  input  mmu_pkg::priv_lvl_t      priv_i,
  input  logic                    sum_i,
  input  logic                    mxr_i,
  // load/store unit
  input  logic                    lsu_req_i,
  input  logic [`MMU_VLEN-1:0]    lsu_vaddr_i,
  input  logic                    lsu_is_store_i,
  output logic                    lsu_dtlb_hit_o,
  output logic                    lsu_valid_o,
  output logic [`MMU_PLEN-1:0]    lsu_paddr_o,
  output mmu_pkg::xlate_exc_t     lsu_exc_o,
  // Wishbone classic master
  output logic                    wb_cyc_o,
  output logic                    wb_stb_o,
  output logic [`MMU_PLEN-1:0]    wb_adr_o,
  input  logic [31:0]             wb_dat_i,
  input  logic                    wb_ack_i,
  input  logic                    wb_err_i
);
  import mmu_pkg::*;

  logic xlate_en;
  logic tlb_req;
  logic tlb_hit;
  logic tlb_miss;
  tlb_entry_t tlb_entry;
  logic refill_valid;
  tlb_entry_t refill;
  logic walk_done;
  logic walk_fault;
  logic walk_access;
  vaddr_u walk_vaddr;
  logic walk_done_here;

  // satp mode 1 is Sv32
  assign xlate_en = satp_i.mode;
  assign tlb_req = lsu_req_i && xlate_en;
  // walker ignores misses while busy
  assign tlb_miss = tlb_req && !tlb_hit;
  // walk result only applies to the address that was walked
  assign walk_done_here = walk_done && (walk_vaddr == lsu_vaddr_i);

  mmu_tlb #(
    .ENTRIES (`MMU_TLB_ENTRIES)
  ) i_dtlb (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .lu_req_i       (tlb_req),
    .lu_vaddr_i     (lsu_vaddr_i),
    .lu_asid_i      (satp_i.asid),
    .refill_valid_i (refill_valid),
    .refill_i       (refill),
    .lu_hit_o       (tlb_hit),
    .lu_entry_o     (tlb_entry)
  );

  mmu_ptw i_ptw (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .miss_i              (tlb_miss),
    .miss_vaddr_i        (lsu_vaddr_i),
    .miss_asid_i         (satp_i.asid),
    .root_ppn_i          (satp_i.ppn),
    .wb_cyc_o            (wb_cyc_o),
    .wb_stb_o            (wb_stb_o),
    .wb_adr_o            (wb_adr_o),
    .wb_dat_i            (wb_dat_i),
    .wb_ack_i            (wb_ack_i),
    .wb_err_i            (wb_err_i),
    .refill_valid_o      (refill_valid),
    .refill_o            (refill),
    .walk_done_o         (walk_done),
    .walk_fault_o        (walk_fault),
    .walk_cause_access_o (walk_access),
    .walk_vaddr_o        (walk_vaddr)
  );

  mmu_xlate i_xlate (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (lsu_req_i),
    .vaddr_i             (lsu_vaddr_i),
    .is_store_i          (lsu_is_store_i),
    .xlate_en_i          (xlate_en),
    .hit_i               (tlb_hit),
    .entry_i             (tlb_entry),
    .priv_i              (priv_i),
    .sum_i               (sum_i),
    .mxr_i               (mxr_i),
    .walk_done_i         (walk_done_here),
    .walk_fault_i        (walk_fault),
    .walk_cause_access_i (walk_access),
    .dtlb_hit_o          (lsu_dtlb_hit_o),
    .valid_o             (lsu_valid_o),
    .paddr_o             (lsu_paddr_o),
    .exc_o               (lsu_exc_o)
  );

endmodule

/* sv32_mmu_assert.sv */
// Protocol checks for the Sv32 MMU
// Wishbone strobe and address hold, bare mode result latency

`timescale 1ns/1ps

`include "mmu_settings.svh"

module sv32_mmu_assert (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    xlate_en_i,
  input  logic                    req_i,
  input  logic                    valid_i,
  input  logic                    cyc_i,
  input  logic                    stb_i,
  input  logic [`MMU_PLEN-1:0]    adr_i,
  input  logic                    ack_i,
  input  logic                    err_i
);

  // ------------------------------------------------------------
  // Wishbone classic master
  // ------------------------------------------------------------
  // unanswered strobe stays up
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   stb_i && !ack_i && !err_i |=> stb_i && cyc_i)
    else $error("wb stb dropped before ack or err");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   stb_i && !ack_i && !err_i |=> $stable(adr_i))
    else $error("wb adr changed while stb waited");

  // answered strobe drops next cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   stb_i && (ack_i || err_i) |=> !stb_i && !cyc_i)
    else $error("wb cyc or stb held after the answer");

  // ------------------------------------------------------------
  // bare mode result one cycle after the request
  // ------------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni) !xlate_en_i && req_i |=> valid_i)
    else $error("bare mode request not answered in the next cycle");

  assert property (@(posedge clk_i) disable iff (!rst_ni) !xlate_en_i && !req_i |=> !valid_i)
    else $error("bare mode result without a request");

endmodule

bind sv32_mmu sv32_mmu_assert i_mmu_assert (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .xlate_en_i (satp_i.mode),
  .req_i      (lsu_req_i),
  .valid_i    (lsu_valid_o),
  .cyc_i      (wb_cyc_o),
  .stb_i      (wb_stb_o),
  .adr_i      (wb_adr_o),
  .ack_i      (wb_ack_i),
  .err_i      (wb_err_i)
);

/* tb_sv32_mmu.sv */
// Random testbench for the Sv32 data MMU
// page table memory, Wishbone slave model and a reference walk

`timescale 1ns/1ps

`include "mmu_settings.svh"

module tb_sv32_mmu;
  import mmu_pkg::*;

  // requests per test, sets the watchdog limit
  localparam int N_BARE = 50;
  localparam int N_PAGE = 5;
  localparam int N_MEGA = 3;
  localparam int N_PERM = 7;
  localparam int N_WFLT = 6;
  localparam int N_FLSH = 6;
  localparam int N_REQ = N_BARE + N_PAGE + N_MEGA + N_PERM + N_WFLT + N_FLSH;
  localparam int MAX_CYCLES = 200 * N_REQ;
  localparam logic [31:0] SEED = 32'hca8a_5541;

  // pte flags, v in bit 0
  localparam logic [7:0] F_V = 8'h01;
  localparam logic [7:0] F_R = 8'h02;
  localparam logic [7:0] F_W = 8'h04;
  localparam logic [7:0] F_X = 8'h08;
  localparam logic [7:0] F_U = 8'h10;
  localparam logic [7:0] F_G = 8'h20;
  localparam logic [7:0] F_A = 8'h40;
  localparam logic [7:0] F_D = 8'h80;

  // root table and the one level 0 table
  localparam logic [21:0] ROOT_PPN = 22'h00080;
  localparam logic [21:0] L0_PPN = 22'h00081;
  // pte slot 9 of the level 0 table answers with err
  localparam logic [33:0] ERR_ADR = {L0_PPN, 10'd9, 2'b00};

  logic clk_i;
  logic rst_ni;
  logic flush_i;
  satp_t satp_i;
  priv_lvl_t priv_i;
  logic sum_i;
  logic mxr_i;
  logic lsu_req_i;
  logic [`MMU_VLEN-1:0] lsu_vaddr_i;
  logic lsu_is_store_i;
  logic lsu_dtlb_hit_o;
  logic lsu_valid_o;
  logic [`MMU_PLEN-1:0] lsu_paddr_o;
  xlate_exc_t lsu_exc_o;
  logic wb_cyc_o;
  logic wb_stb_o;
  logic [`MMU_PLEN-1:0] wb_adr_o;
  logic [31:0] wb_dat_i;
  logic wb_ack_i;
  logic wb_err_i;

  // page table, missing words read as zero (invalid pte)
  logic [31:0] ptmem [logic [`MMU_PLEN-1:0]];
  integer seed;
  logic wb_busy;
  logic [1:0] wb_wait;
  int rd_count;
  int cycle_cnt;
  int n_chk;
  int n_err;
  int chk_base;
  int err_base;

  sv32_mmu DUT (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .satp_i         (satp_i),
    .priv_i         (priv_i),
    .sum_i          (sum_i),
    .mxr_i          (mxr_i),
    .lsu_req_i      (lsu_req_i),
    .lsu_vaddr_i    (lsu_vaddr_i),
    .lsu_is_store_i (lsu_is_store_i),
    .lsu_dtlb_hit_o (lsu_dtlb_hit_o),
    .lsu_valid_o    (lsu_valid_o),
    .lsu_paddr_o    (lsu_paddr_o),
    .lsu_exc_o      (lsu_exc_o),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_adr_o       (wb_adr_o),
    .wb_dat_i       (wb_dat_i),
    .wb_ack_i       (wb_ack_i),
    .wb_err_i       (wb_err_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // Wishbone slave, 0 to 3 random wait states
  // ------------------------------------------------------------
  always @(posedge clk_i) begin : wb_slave
    logic [31:0] r;
    wb_ack_i <= 1'b0;
    wb_err_i <= 1'b0;
    if (wb_stb_o && !wb_ack_i && !wb_err_i) begin
      if (!wb_busy) begin
        r = $random(seed);
        wb_wait <= r[1:0];
        wb_busy <= 1'b1;
      end else if (wb_wait != 2'd0) begin
        wb_wait <= wb_wait - 2'd1;
      end else begin
        wb_busy  <= 1'b0;
        wb_dat_i <= mem_rd(wb_adr_o);
        rd_count <= rd_count + 1;
        if (wb_adr_o == ERR_ADR) begin
          wb_err_i <= 1'b1;
        end else begin
          wb_ack_i <= 1'b1;
        end
      end
    end
  end

  // watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("Test failures found");
    $finish;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] mem_rd(input logic [`MMU_PLEN-1:0] a);
    if (ptmem.exists(a)) begin
      return ptmem[a];
    end
    return 32'h0;
  endfunction

  function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
    return {ppn, 2'b00, flags};
  endfunction

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // 4 KiB page address with a random offset
  function automatic logic [31:0] rand_va(input logic [9:0] vpn1, input logic [9:0] vpn0);
    logic [31:0] r;
    r = $random(seed);
    return {vpn1, vpn0, r[11:0]};
  endfunction

  // megapage address with a random 22-bit offset
  function automatic logic [31:0] rand_mega_va(input logic [9:0] vpn1);
    logic [31:0] r;
    r = $random(seed);
    return {vpn1, r[21:0]};
  endfunction

  task automatic l0_leaf(input logic [9:0] vpn0, input logic [7:0] flags);
    logic [31:0] r;
    r = $random(seed);
    ptmem[{L0_PPN, vpn0, 2'b00}] = make_pte(r[21:0], flags);
  endtask

  task automatic build_table();
    logic [31:0] r;
    // vpn1 1 points at the level 0 table
    ptmem[{ROOT_PPN, 10'd1, 2'b00}] = make_pte(L0_PPN, F_V);
    // vpn1 2 good megapage, vpn1 3 misaligned one
    r = $random(seed);
    ptmem[{ROOT_PPN, 10'd2, 2'b00}] = make_pte({r[11:0], 10'd0}, F_V | F_R | F_W | F_A | F_D);
    r = $random(seed);
    ptmem[{ROOT_PPN, 10'd3, 2'b00}] = make_pte({r[11:0], 10'h155}, F_V | F_R | F_A);
    l0_leaf(10'd0, F_V | F_R | F_W | F_A | F_D);
    // read only
    l0_leaf(10'd1, F_V | F_R | F_A | F_D);
    // dirty clear
    l0_leaf(10'd2, F_V | F_R | F_W | F_A);
    l0_leaf(10'd3, F_V | F_R | F_W | F_A | F_D | F_U);
    // execute only
    l0_leaf(10'd4, F_X | F_V | F_A);
    // corrupted: v clear, then w without r
    l0_leaf(10'd5, F_R | F_W | F_A | F_D);
    l0_leaf(10'd6, F_V | F_W | F_A | F_D);
    l0_leaf(10'd7, F_V | F_R | F_W | F_A | F_D | F_G);
    // pointer where a leaf must be
    l0_leaf(10'd10, F_V);
  endtask

  // reference walk and permission rules
  task automatic model_translate(input logic [31:0] va, input logic st,
                                 output logic [`MMU_PLEN-1:0] pa, output logic exc,
                                 output logic [3:0] cause, output int reads);
    logic [`MMU_PLEN-1:0] adr;
    pte_t pte;
    logic mega;
    logic page_f;
    logic acc_f;
    logic ok;
    pa = {2'b00, va};
    reads = 0;
    mega = 1'b0;
    page_f = 1'b0;
    acc_f = 1'b0;
    if (satp_i.mode) begin
      adr = {satp_i.ppn, va[31:22], 2'b00};
      reads = 1;
      pte = pte_t'(mem_rd(adr));
      if (adr == ERR_ADR) begin
        acc_f = 1'b1;
      end else if (!pte.v || (pte.w && !pte.r)) begin
        page_f = 1'b1;
      end else if (pte.r || pte.x) begin
        mega = 1'b1;
        page_f = (pte.ppn[9:0] != 10'd0);
      end else begin
        adr = {pte.ppn, va[21:12], 2'b00};
        reads = 2;
        pte = pte_t'(mem_rd(adr));
        if (adr == ERR_ADR) begin
          acc_f = 1'b1;
        end else begin
          page_f = !pte.v || (pte.w && !pte.r) || !(pte.r || pte.x);
        end
      end
      if (!page_f && !acc_f) begin
        pa = mega ? {pte.ppn[21:10], va[21:0]} : {pte.ppn, va[11:0]};
        ok = st ? (pte.w && pte.d) : (pte.r || (pte.x && mxr_i));
        ok = ok && pte.a;
        if (priv_i == PRIV_LVL_U) begin
          ok = ok && pte.u;
        end else begin
          ok = ok && (!pte.u || sum_i);
        end
        page_f = !ok;
      end
    end
    exc = page_f || acc_f;
    if (acc_f) begin
      cause = st ? `MMU_CAUSE_ST_ACCESS : `MMU_CAUSE_LD_ACCESS;
    end else begin
      cause = st ? `MMU_CAUSE_ST_PAGE : `MMU_CAUSE_LD_PAGE;
    end
  endtask

  task automatic check_value(input string name, input logic [33:0] got,
                             input logic [33:0] exp);
    n_chk++;
    assert (got === exp) else begin
      $display("error: %s got %h expected %h", name, got, exp);
      n_err++;
    end
  endtask

  // ------------------------------------------------------------
  // stimulus tasks
  // ------------------------------------------------------------
  task automatic program_csr(input logic mode, input logic [8:0] asid, input priv_lvl_t priv,
                             input logic sum, input logic mxr);
    @(posedge clk_i);
    satp_i <= '{mode: mode, asid: asid, ppn: ROOT_PPN};
    priv_i <= priv;
    sum_i  <= sum;
    mxr_i  <= mxr;
  endtask

  task automatic do_flush();
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
  endtask

  // one-cycle request, retried until answered
  task automatic run_access(input logic [31:0] va, input logic st, input logic exp_walk);
    logic [`MMU_PLEN-1:0] exp_pa;
    logic exp_exc;
    logic [3:0] exp_cause;
    int exp_reads;
    int rd_before;
    int tries;
    logic first_hit;
    logic got;
    logic [`MMU_PLEN-1:0] got_pa;
    xlate_exc_t got_exc;
    rd_before = rd_count;
    tries = 0;
    got = 1'b0;
    first_hit = 1'b0;
    while (!got) begin
      @(posedge clk_i);
      lsu_req_i      <= 1'b1;
      lsu_vaddr_i    <= va;
      lsu_is_store_i <= st;
      @(negedge clk_i);
      if (tries == 0) begin
        first_hit = lsu_dtlb_hit_o;
        model_translate(va, st, exp_pa, exp_exc, exp_cause, exp_reads);
      end
      @(posedge clk_i);
      lsu_req_i <= 1'b0;
      @(negedge clk_i);
      got = lsu_valid_o;
      got_pa = lsu_paddr_o;
      got_exc = lsu_exc_o;
      tries++;
    end
    // hits and bare requests answer in the next cycle
    n_chk++;
    assert (exp_walk || tries == 1) else begin
      $display("request to %h was not answered in the cycle after it", va);
      n_err++;
    end
    if (satp_i.mode) begin
      check_value("lsu_dtlb_hit_o", first_hit, !exp_walk);
    end
    check_value("wb reads", rd_count - rd_before, exp_walk ? exp_reads : 0);
    check_value("lsu_exc_o.valid", got_exc.valid, exp_exc);
    if (exp_exc) begin
      check_value("lsu_exc_o.cause", got_exc.cause, exp_cause);
      check_value("lsu_exc_o.tval", got_exc.tval, va);
    end else begin
      check_value("lsu_paddr_o", got_pa, exp_pa);
    end
  endtask

  task automatic begin_test();
    chk_base = n_chk;
    err_base = n_err;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, n_chk - chk_base, n_err - err_base);
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    logic [31:0] va;
    rst_ni = 1'b0;
    flush_i = 1'b0;
    satp_i = '0;
    priv_i = PRIV_LVL_S;
    sum_i = 1'b0;
    mxr_i = 1'b0;
    lsu_req_i = 1'b0;
    lsu_vaddr_i = '0;
    lsu_is_store_i = 1'b0;
    wb_dat_i = '0;
    wb_ack_i = 1'b0;
    wb_err_i = 1'b0;
    wb_busy = 1'b0;
    wb_wait = 2'd0;
    rd_count = 0;
    n_chk = 0;
    n_err = 0;
    seed = SEED;
    build_table();
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;

    begin_test();
    program_csr(1'b0, 9'd0, PRIV_LVL_S, 1'b0, 1'b0);
    repeat (N_BARE) run_access($random(seed), rand_bit(), 1'b0);
    end_test("bare mode");

    // first touch walks, then hits on other offsets
    begin_test();
    program_csr(1'b1, 9'd1, PRIV_LVL_S, 1'b0, 1'b0);
    do_flush();
    run_access(rand_va(10'd1, 10'd0), 1'b0, 1'b1);
    repeat (N_PAGE - 1) run_access(rand_va(10'd1, 10'd0), rand_bit(), 1'b0);
    end_test("4 KiB pages");

    begin_test();
    do_flush();
    run_access(rand_mega_va(10'd2), rand_bit(), 1'b1);
    repeat (N_MEGA - 1) run_access(rand_mega_va(10'd2), rand_bit(), 1'b0);
    end_test("megapages");

    begin_test();
    do_flush();
    run_access(rand_va(10'd1, 10'd1), 1'b1, 1'b1);
    run_access(rand_va(10'd1, 10'd2), 1'b1, 1'b1);
    run_access(rand_va(10'd1, 10'd3), 1'b0, 1'b1);
    run_access(rand_va(10'd1, 10'd4), 1'b0, 1'b1);
    // sum and mxr open the same TLB entries
    program_csr(1'b1, 9'd1, PRIV_LVL_S, 1'b1, 1'b1);
    run_access(rand_va(10'd1, 10'd3), rand_bit(), 1'b0);
    run_access(rand_va(10'd1, 10'd4), 1'b0, 1'b0);
    program_csr(1'b1, 9'd1, PRIV_LVL_U, 1'b0, 1'b0);
    run_access(rand_va(10'd1, 10'd0), 1'b0, 1'b1);
    end_test("permissions");

    // faulted walks leave no entry behind
    begin_test();
    program_csr(1'b1, 9'd1, PRIV_LVL_S, 1'b0, 1'b0);
    do_flush();
    run_access(rand_va(10'd1, 10'd5), rand_bit(), 1'b1);
    run_access(rand_va(10'd1, 10'd6), rand_bit(), 1'b1);
    run_access(rand_mega_va(10'd3), rand_bit(), 1'b1);
    run_access(rand_va(10'd1, 10'd9), rand_bit(), 1'b1);
    run_access(rand_va(10'd1, 10'd10), rand_bit(), 1'b1);
    run_access(rand_va(10'd1, 10'd5), rand_bit(), 1'b1);
    end_test("walk faults");

    begin_test();
    do_flush();
    va = rand_va(10'd1, 10'd0);
    run_access(va, 1'b0, 1'b1);
    run_access(va, 1'b0, 1'b0);
    do_flush();
    run_access(va, 1'b0, 1'b1);
    // non-global entry no longer matches
    program_csr(1'b1, 9'd2, PRIV_LVL_S, 1'b0, 1'b0);
    run_access(va, 1'b0, 1'b1);
    va = rand_va(10'd1, 10'd7);
    run_access(va, 1'b0, 1'b1);
    program_csr(1'b1, 9'd3, PRIV_LVL_S, 1'b0, 1'b0);
    run_access(va, 1'b0, 1'b0);
    end_test("flush and asid");

    $display("total: %0d checks, %0d errors", n_chk, n_err);
    if (n_err == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
